//--- exec_top.f
common/exec_pkg.sv
common/muldiv_pkg.sv
common/lane_if.sv
hw/exec_dispatch.sv
hw/alu_lane.sv
muldiv/mul_unit.sv
muldiv/div_unit.sv
hw/exec_writeback.sv
hw/exec_top.sv
test/exec_top_assert.sv
test/exec_top_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f exec_top.f --top-module exec_top_tb -o exec_top_sim

out=$(./obj_dir/exec_top_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "TEST OK"

//--- test/exec_top_tb.sv
`timescale 1ns/1ps

module exec_top_tb;
    import exec_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_BUNDLES = 260;

    logic        clk;
    logic        rst_i;
    logic        flush_i;
    alu_op_e     op_i    [2];
    logic [31:0] src_a_i [2];
    logic [31:0] src_b_i [2];
    logic [4:0]  shamt_i [2];
    logic [31:0] result_o   [2];
    logic        overflow_o [2];
    logic        stall_o;
    logic [63:0] hilo_o;

    integer      seed = 32'h2d4b;
    int          err_count = 0;
    int          stall_cycles;
    logic [63:0] hilo_exp;

    exec_top #(.LANES(2)) u_exec_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(40 * NUM_BUNDLES * CLK_PERIOD);
        $display("Timeout: the DUT did not finish the tests in time");
        $display("TEST FAILED");
        $fatal(1);
    end

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive_slot(int s, alu_op_e op, logic [31:0] a, logic [31:0] b,
                              logic [4:0] sh);
        op_i[s]    <= op;
        src_a_i[s] <= a;
        src_b_i[s] <= b;
        shamt_i[s] <= sh;
    endtask

    // issue one bundle, hold it through the stall, then return to nops
    task automatic run_bundle(alu_op_e op0, logic [31:0] a0, logic [31:0] b0, logic [4:0] sh0,
                              alu_op_e op1, logic [31:0] a1, logic [31:0] b1, logic [4:0] sh1);
        @(posedge clk);
        drive_slot(0, op0, a0, b0, sh0);
        drive_slot(1, op1, a1, b1, sh1);
        stall_cycles = 0;
        @(negedge clk);
        while (stall_o) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        drive_slot(0, OP_NOP, 0, 0, 0);
        drive_slot(1, OP_NOP, 0, 0, 0);
        @(negedge clk);
    endtask

    task automatic alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b, logic [4:0] sh,
                             output logic [31:0] res, output logic ovf);
        logic [32:0] wide;
        res = 0;
        ovf = 0;
        case (op)
            OP_ADD, OP_ADDU: begin
                wide = {a[31], a} + {b[31], b};
                res  = wide[31:0];
                ovf  = (op == OP_ADD) && (wide[32] != wide[31]);
            end
            OP_SUB, OP_SUBU: begin
                wide = {a[31], a} - {b[31], b};
                res  = wide[31:0];
                ovf  = (op == OP_SUB) && (wide[32] != wide[31]);
            end
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_NOR:  res = ~(a | b);
            OP_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU: res = {31'b0, a < b};
            OP_SLL:  res = b << sh;
            OP_SRL:  res = b >> sh;
            OP_SRA:  res = 32'($signed(b) >>> sh);
            OP_LUI:  res = {b[15:0], 16'h0};
            default: res = 0;
        endcase
    endtask

    function automatic logic [63:0] product(logic [31:0] a, logic [31:0] b, bit sgn);
        if (sgn)
            return $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        return {32'b0, a} * {32'b0, b};
    endfunction

    function automatic logic [63:0] div_model(logic [31:0] a, logic [31:0] b, bit sgn);
        longint q;
        longint r;
        if (b == 0)
            return {a, 32'hffff_ffff}; // remainder keeps the dividend
        if (sgn) begin
            q = longint'($signed(a)) / longint'($signed(b));
            r = longint'($signed(a)) % longint'($signed(b));
        end else begin
            q = longint'({32'b0, a}) / longint'({32'b0, b});
            r = longint'({32'b0, a}) % longint'({32'b0, b});
        end
        return {r[31:0], q[31:0]};
    endfunction

    task automatic test_alu_random();
        alu_op_e     ops [13] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR,
                                  OP_NOR, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA};
        alu_op_e     op [2];
        logic [31:0] a [2];
        logic [31:0] b [2];
        logic [4:0]  sh [2];
        logic [31:0] res;
        logic        ovf;
        for (int n = 0; n < 200; n++) begin
            for (int s = 0; s < 2; s++) begin
                op[s] = (n % 50 == 0) ? OP_LUI : ops[$unsigned($random(seed)) % 13];
                a[s]  = $random(seed);
                b[s]  = $random(seed);
                sh[s] = $random(seed);
            end
            run_bundle(op[0], a[0], b[0], sh[0], op[1], a[1], b[1], sh[1]);
            for (int s = 0; s < 2; s++) begin
                alu_model(op[s], a[s], b[s], sh[s], res, ovf);
                check_val($sformatf("result_o[%0d]", s), result_o[s], res);
                check_val($sformatf("overflow_o[%0d]", s), overflow_o[s], ovf);
            end
        end
    endtask

    task automatic test_hilo_moves();
        run_bundle(OP_MTHI, 32'h1234_5678, 0, 0, OP_NOP, 0, 0, 0);
        check_val("hilo_o", hilo_o[63:32], 32'h1234_5678);
        run_bundle(OP_NOP, 0, 0, 0, OP_MTLO, 32'h9abc_def0, 0, 0);
        check_val("hilo_o", hilo_o, 64'h1234_5678_9abc_def0);
        run_bundle(OP_MFHI, 0, 0, 0, OP_MFLO, 0, 0, 0);
        check_val("result_o[0]", result_o[0], 32'h1234_5678);
        check_val("result_o[1]", result_o[1], 32'h9abc_def0);
    endtask

    // slot alternates so both lanes reach the shared unit
    task automatic issue_md(int slot, alu_op_e op, logic [31:0] a, logic [31:0] b);
        if (slot == 0)
            run_bundle(op, a, b, 0, OP_NOP, 0, 0, 0);
        else
            run_bundle(OP_NOP, 0, 0, 0, op, a, b, 0);
    endtask

    task automatic test_mult();
        logic [31:0] a [12] = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 0,
                                 32'hffff_ffff, 7, 0, 0, 0, 0, 0, 0};
        logic [31:0] b [12] = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h1234,
                                 32'h8000_0000, 32'hffff_fff9, 0, 0, 0, 0, 0, 0};
        bit          sgn;
        for (int n = 6; n < 12; n++) begin
            a[n] = $random(seed);
            b[n] = $random(seed);
        end
        for (int n = 0; n < 24; n++) begin
            sgn = n % 2;
            issue_md(n % 2, sgn ? OP_MULT : OP_MULTU, a[n / 2], b[n / 2]);
            check_val("stall_o cycles", stall_cycles, 2);
            check_val("hilo_o", hilo_o, product(a[n / 2], b[n / 2], sgn));
        end
    endtask

    task automatic test_div();
        logic [31:0] a [10] = '{32'hffff_fff9, 7, 32'hffff_fff9, 32'h8000_0000, 32'h1234,
                                 32'hffff_ff00, 0, 0, 0, 0};
        logic [31:0] b [10] = '{2, 32'hffff_fffe, 32'hffff_fffe, 32'hffff_ffff, 0,
                                 0, 0, 0, 0, 0};
        bit          sgn;
        for (int n = 6; n < 10; n++) begin
            a[n] = $random(seed);
            b[n] = $random(seed) >> (n * 3);
        end
        for (int n = 0; n < 20; n++) begin
            sgn = (n % 2 == 0);
            issue_md(n % 2, sgn ? OP_DIV : OP_DIVU, a[n / 2], b[n / 2]);
            check_val("stall_o cycles", stall_cycles, 34);
            check_val("hilo_o", hilo_o, div_model(a[n / 2], b[n / 2], sgn));
        end
    endtask

    task automatic test_madd_msub();
        logic [31:0] a;
        logic [31:0] b;
        run_bundle(OP_MTHI, 32'h0000_0010, 0, 0, OP_NOP, 0, 0, 0);
        run_bundle(OP_NOP, 0, 0, 0, OP_MTLO, 32'hfff0_0000, 0, 0);
        hilo_exp = 64'h0000_0010_fff0_0000;
        check_val("hilo_o", hilo_o, hilo_exp);
        for (int n = 0; n < 8; n++) begin
            a = $random(seed);
            b = $random(seed);
            if (n % 2 == 0) begin
                issue_md(n % 2, OP_MADD, a, b);
                hilo_exp = hilo_exp + product(a, b, 1);
            end else begin
                issue_md(n % 2, OP_MSUB, a, b);
                hilo_exp = hilo_exp - product(a, b, 1);
            end
            check_val("hilo_o", hilo_o, hilo_exp);
        end
    endtask

    task automatic test_flush_div();
        @(posedge clk);
        drive_slot(0, OP_DIV, 32'h0000_1000, 32'h0000_0003, 0);
        repeat (6) @(negedge clk);
        check_val("stall_o", stall_o, 1);
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        drive_slot(0, OP_NOP, 0, 0, 0);
        @(negedge clk);
        check_val("stall_o", stall_o, 0);
        check_val("hilo_o", hilo_o, hilo_exp);
        // flushed mthi must leave hi alone
        @(posedge clk);
        drive_slot(0, OP_MTHI, 32'h5a5a_0001, 0, 0);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        drive_slot(0, OP_NOP, 0, 0, 0);
        @(negedge clk);
        check_val("hilo_o", hilo_o, hilo_exp);
        // new operands, so a divider left running shows up
        issue_md(1, OP_DIVU, 32'h0000_2000, 32'h0000_0007);
        check_val("stall_o cycles", stall_cycles, 34);
        check_val("hilo_o", hilo_o, {32'h2, 32'h492});
    endtask

    initial begin
        rst_i   = 1'b1;
        flush_i = 1'b0;
        for (int s = 0; s < 2; s++) begin
            op_i[s]    = OP_NOP;
            src_a_i[s] = 0;
            src_b_i[s] = 0;
            shamt_i[s] = 0;
        end
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_val("stall_o", stall_o, 0);
        check_val("hilo_o", hilo_o, 0);
        check_val("result_o[0]", result_o[0], 0);

        test_alu_random();
        test_hilo_moves();
        test_mult();
        test_div();
        test_madd_msub();
        test_flush_div();

        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test/exec_top_assert.sv
`timescale 1ns/1ps

module exec_top_assert (
    input logic        clk,
    input logic        rst_i,
    input logic        flush_i,
    input logic        stall_i,
    input logic        mul_ready_i,
    input logic        div_ready_i,
    input logic [63:0] hilo_i
);

    a_no_stall_in_reset: assert property (@(posedge clk) rst_i |-> !stall_i)
        else $error("stall high during reset");

    a_mul_ready_pulse: assert property (@(posedge clk) disable iff (rst_i)
        mul_ready_i |=> !mul_ready_i)
        else $error("mul ready longer than one cycle");

    a_div_ready_pulse: assert property (@(posedge clk) disable iff (rst_i)
        div_ready_i |=> !div_ready_i)
        else $error("div ready longer than one cycle");

    // stall drops together with the answering ready
    a_stall_on_ready: assert property (@(posedge clk) disable iff (rst_i)
        (mul_ready_i || div_ready_i) |-> $fell(stall_i))
        else $error("stall did not fall on ready");

    a_flush_keeps_hilo: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |=> $stable(hilo_i))
        else $error("hi/lo written in a flushed cycle");

endmodule

bind exec_top exec_top_assert u_assert (
    .clk         (clk),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .stall_i     (stall_o),
    .mul_ready_i (mul_ready),
    .div_ready_i (div_ready),
    .hilo_i      (hilo_o)
);

//--- hw/exec_top.sv
`timescale 1ns/1ps

module exec_top #(
    parameter int LANES = 2
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          flush_i,
    input  exec_pkg::alu_op_e             op_i       [LANES],
    input  logic [exec_pkg::XLEN-1:0]     src_a_i    [LANES],
    input  logic [exec_pkg::XLEN-1:0]     src_b_i    [LANES],
    input  logic [4:0]                    shamt_i    [LANES],
    output logic [exec_pkg::XLEN-1:0]     result_o   [LANES],
    output logic                          overflow_o [LANES],
    output logic                          stall_o,
    output logic [2*exec_pkg::XLEN-1:0]   hilo_o
);
    import exec_pkg::*;
    import muldiv_pkg::*;

    muldiv_op_e        md_op;
    logic [XLEN-1:0]   md_a;
    logic [XLEN-1:0]   md_b;
    logic              md_signed;
    logic              mul_start;
    logic              div_start;
    logic              mul_ready;
    logic              div_ready;
    logic [2*XLEN-1:0] mul_result;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;

    lane_if lanes [LANES] ();

    exec_dispatch #(.LANES(LANES)) u_dispatch (
        .op_i        (op_i),
        .src_a_i     (src_a_i),
        .src_b_i     (src_b_i),
        .shamt_i     (shamt_i),
        .lanes       (lanes),
        .mul_ready_i (mul_ready),
        .div_ready_i (div_ready),
        .md_op_o     (md_op),
        .md_a_o      (md_a),
        .md_b_o      (md_b),
        .md_signed_o (md_signed),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .stall_o     (stall_o)
    );

    genvar i;
    generate
        for (i = 0; i < LANES; i++) begin : g_alu
            alu_lane u_alu (.lane(lanes[i]));
        end
    endgenerate

    mul_unit u_mul (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (flush_i),
        .start_i  (mul_start),
        .signed_i (md_signed),
        .a_i      (md_a),
        .b_i      (md_b),
        .ready_o  (mul_ready),
        .result_o (mul_result)
    );

    div_unit u_div (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .start_i     (div_start),
        .signed_i    (md_signed),
        .dividend_i  (md_a),
        .divisor_i   (md_b),
        .ready_o     (div_ready),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    exec_writeback #(.LANES(LANES)) u_writeback (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .lanes        (lanes),
        .md_op_i      (md_op),
        .md_a_i       (md_a),
        .mul_ready_i  (mul_ready),
        .mul_result_i (mul_result),
        .div_ready_i  (div_ready),
        .quotient_i   (quotient),
        .remainder_i  (remainder),
        .stall_i      (stall_o),
        .result_o     (result_o),
        .overflow_o   (overflow_o),
        .hilo_o       (hilo_o)
    );

endmodule

//--- hw/exec_writeback.sv
`timescale 1ns/1ps

module exec_writeback #(
    parameter int LANES = 2
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          flush_i,
    lane_if.wb                            lanes [LANES],
    input  muldiv_pkg::muldiv_op_e        md_op_i,
    input  logic [exec_pkg::XLEN-1:0]     md_a_i,
    input  logic                          mul_ready_i,
    input  logic [2*exec_pkg::XLEN-1:0]   mul_result_i,
    input  logic                          div_ready_i,
    input  logic [exec_pkg::XLEN-1:0]     quotient_i,
    input  logic [exec_pkg::XLEN-1:0]     remainder_i,
    input  logic                          stall_i,
    output logic [exec_pkg::XLEN-1:0]     result_o   [LANES],
    output logic                          overflow_o [LANES],
    output logic [2*exec_pkg::XLEN-1:0]   hilo_o
);
    import exec_pkg::*;
    import muldiv_pkg::*;

    logic [XLEN-1:0]   lane_res [LANES];
    logic              lane_ovf [LANES];
    logic [2*XLEN-1:0] hilo_q;
    logic [2*XLEN-1:0] hilo_d;
    logic              hilo_we;

    genvar i;
    generate
        for (i = 0; i < LANES; i++) begin : g_lane
            assign lane_res[i]   = lanes[i].result;
            assign lane_ovf[i]   = lanes[i].overflow;
            assign lanes[i].hilo = hilo_q;
        end
    endgenerate

    // results freeze while the bundle is stalled
    always_ff @(posedge clk) begin
        for (int s = 0; s < LANES; s++) begin
            if (rst_i) begin
                result_o[s]   <= '0;
                overflow_o[s] <= 1'b0;
            end else if (!stall_i) begin
                result_o[s]   <= lane_res[s];
                overflow_o[s] <= lane_ovf[s];
            end
        end
    end

    always_comb begin
        hilo_d = hilo_q;
        case (md_op_i)
            MD_MUL:  hilo_d = mul_result_i;
            MD_MADD: hilo_d = hilo_q + mul_result_i;
            MD_MSUB: hilo_d = hilo_q - mul_result_i;
            MD_DIV:  hilo_d = {remainder_i, quotient_i}; // hi gets remainder
            MD_MTHI: hilo_d = {md_a_i, hilo_q[XLEN-1:0]};
            MD_MTLO: hilo_d = {hilo_q[2*XLEN-1:XLEN], md_a_i};
            default: hilo_d = hilo_q;
        endcase
    end

    assign hilo_we = !flush_i &&
                     ((md_op_i inside {MD_MTHI, MD_MTLO}) ||
                      ((md_op_i inside {MD_MUL, MD_MADD, MD_MSUB}) && mul_ready_i) ||
                      (md_op_i == MD_DIV && div_ready_i));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            hilo_q <= hilo_d;
        end
    end

    assign hilo_o = hilo_q;

endmodule

//--- muldiv/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        flush_i,
    input  logic                        start_i,
    input  logic                        signed_i,
    input  logic [exec_pkg::XLEN-1:0]   dividend_i,
    input  logic [exec_pkg::XLEN-1:0]   divisor_i,
    output logic                        ready_o,
    output logic [exec_pkg::XLEN-1:0]   quotient_o,
    output logic [exec_pkg::XLEN-1:0]   remainder_o
);
    import exec_pkg::*;
    import muldiv_pkg::*;

    localparam int CW = $clog2(XLEN);

    div_state_e      state_q;
    logic [CW-1:0]   cnt_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;    // dividend shifts out, quotient bits shift in
    logic [XLEN-1:0] dvs_q;
    logic            q_neg;
    logic            r_neg;
    logic            dvs_zero;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;

    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (start_i) begin
                        state_q <= DIV_RUN;
                        cnt_q   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CW'(XLEN - 1)) begin
                        state_q <= DIV_FIX;
                    end
                end
                DIV_FIX:  state_q <= DIV_DONE;
                default:  state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            DIV_IDLE: begin
                if (start_i) begin
                    rem_q    <= '0;
                    quo_q    <= (signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
                    dvs_q    <= (signed_i && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;
                    q_neg    <= signed_i && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
                    r_neg    <= signed_i && dividend_i[XLEN-1];
                    dvs_zero <= (divisor_i == '0);
                end
            end
            DIV_RUN: begin
                // negative trial keeps the shifted remainder
                rem_q <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], ~diff[XLEN]};
            end
            DIV_FIX: begin
                quo_q <= dvs_zero ? '1 : (q_neg ? -quo_q : quo_q);
                rem_q <= r_neg ? -rem_q : rem_q; // x/0 leaves the dividend here
            end
            default: ;
        endcase
    end

    assign ready_o     = (state_q == DIV_DONE);
    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule

//--- muldiv/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          flush_i,
    input  logic                          start_i,
    input  logic                          signed_i,
    input  logic [exec_pkg::XLEN-1:0]     a_i,
    input  logic [exec_pkg::XLEN-1:0]     b_i,
    output logic                          ready_o,
    output logic [2*exec_pkg::XLEN-1:0]   result_o
);
    import exec_pkg::*;

    logic              busy_q;   // operands latched
    logic              take;
    logic              neg_q;
    logic [XLEN-1:0]   a_q;
    logic [XLEN-1:0]   b_q;
    logic [2*XLEN-1:0] prod;

    assign take = start_i && !busy_q && !ready_o;

    assign prod = {{XLEN{1'b0}}, a_q} * {{XLEN{1'b0}}, b_q};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy_q  <= 1'b0;
            ready_o <= 1'b0;
        end else begin
            busy_q  <= take;
            ready_o <= busy_q;
        end
    end

    // magnitudes in, sign restored on the product
    always_ff @(posedge clk) begin
        if (take) begin
            a_q   <= (signed_i && a_i[XLEN-1]) ? -a_i : a_i;
            b_q   <= (signed_i && b_i[XLEN-1]) ? -b_i : b_i;
            neg_q <= signed_i && (a_i[XLEN-1] ^ b_i[XLEN-1]);
        end
        if (busy_q) begin
            result_o <= neg_q ? -prod : prod;
        end
    end

endmodule

//--- hw/alu_lane.sv
`timescale 1ns/1ps

module alu_lane (
    lane_if.alu lane
);
    import exec_pkg::*;

    logic [XLEN-1:0] add_res;
    logic [XLEN-1:0] sub_res;
    logic            add_ovf;
    logic            sub_ovf;

    assign add_res = lane.src_a + lane.src_b;
    assign sub_res = lane.src_a - lane.src_b;

    // signs agree going in, differ coming out
    assign add_ovf = (lane.src_a[XLEN-1] == lane.src_b[XLEN-1]) &&
                     (add_res[XLEN-1] != lane.src_a[XLEN-1]);
    assign sub_ovf = (lane.src_a[XLEN-1] != lane.src_b[XLEN-1]) &&
                     (sub_res[XLEN-1] != lane.src_a[XLEN-1]);

    always_comb begin
        lane.result   = '0;
        lane.overflow = 1'b0;
        case (lane.op)
            OP_ADD: begin
                lane.result   = add_res;
                lane.overflow = add_ovf;
            end
            OP_SUB: begin
                lane.result   = sub_res;
                lane.overflow = sub_ovf;
            end
            OP_ADDU:  lane.result = add_res;
            OP_SUBU:  lane.result = sub_res;
            OP_AND:   lane.result = lane.src_a & lane.src_b;
            OP_OR:    lane.result = lane.src_a | lane.src_b;
            OP_XOR:   lane.result = lane.src_a ^ lane.src_b;
            OP_NOR:   lane.result = ~(lane.src_a | lane.src_b);
            OP_SLT:   lane.result = XLEN'($signed(lane.src_a) < $signed(lane.src_b));
            OP_SLTU:  lane.result = XLEN'(lane.src_a < lane.src_b);
            // shifts act on src_b (rt)
            OP_SLL:   lane.result = lane.src_b << lane.shamt;
            OP_SRL:   lane.result = lane.src_b >> lane.shamt;
            OP_SRA:   lane.result = $signed(lane.src_b) >>> lane.shamt;
            OP_LUI:   lane.result = {lane.src_b[15:0], 16'b0};
            OP_MFHI:  lane.result = lane.hilo[2*XLEN-1:XLEN];
            OP_MFLO:  lane.result = lane.hilo[XLEN-1:0];
            default:  lane.result = '0; // muldiv and mt* write hi/lo only
        endcase
    end

endmodule

//--- hw/exec_dispatch.sv
`timescale 1ns/1ps

module exec_dispatch #(
    parameter int LANES = 2
) (
    input  exec_pkg::alu_op_e           op_i    [LANES],
    input  logic [exec_pkg::XLEN-1:0]   src_a_i [LANES],
    input  logic [exec_pkg::XLEN-1:0]   src_b_i [LANES],
    input  logic [4:0]                  shamt_i [LANES],
    lane_if.disp                        lanes   [LANES],
    input  logic                        mul_ready_i,
    input  logic                        div_ready_i,
    output muldiv_pkg::muldiv_op_e      md_op_o,
    output logic [exec_pkg::XLEN-1:0]   md_a_o,
    output logic [exec_pkg::XLEN-1:0]   md_b_o,
    output logic                        md_signed_o,
    output logic                        mul_start_o,
    output logic                        div_start_o,
    output logic                        stall_o
);
    import exec_pkg::*;
    import muldiv_pkg::*;

    function automatic muldiv_op_e decode_md(alu_op_e op);
        case (op)
            OP_MULT, OP_MULTU: return MD_MUL;
            OP_MADD:           return MD_MADD;
            OP_MSUB:           return MD_MSUB;
            OP_DIV, OP_DIVU:   return MD_DIV;
            OP_MTHI:           return MD_MTHI;
            OP_MTLO:           return MD_MTLO;
            default:           return MD_NONE;
        endcase
    endfunction

    genvar i;
    generate
        for (i = 0; i < LANES; i++) begin : g_lane
            assign lanes[i].op    = op_i[i];
            assign lanes[i].src_a = src_a_i[i];
            assign lanes[i].src_b = src_b_i[i];
            assign lanes[i].shamt = shamt_i[i];
        end
    endgenerate

    // highest slot is scanned first and keeps the unit
    always_comb begin
        md_op_o     = MD_NONE;
        md_a_o      = '0;
        md_b_o      = '0;
        md_signed_o = 1'b0;
        for (int s = LANES - 1; s >= 0; s--) begin
            if (md_op_o == MD_NONE && decode_md(op_i[s]) != MD_NONE) begin
                md_op_o     = decode_md(op_i[s]);
                md_a_o      = src_a_i[s];
                md_b_o      = src_b_i[s];
                md_signed_o = op_i[s] inside {OP_MULT, OP_MADD, OP_MSUB, OP_DIV};
            end
        end
    end

    // start held as a level until the unit answers
    assign mul_start_o = (md_op_o inside {MD_MUL, MD_MADD, MD_MSUB}) && !mul_ready_i;
    assign div_start_o = (md_op_o == MD_DIV) && !div_ready_i;

    assign stall_o = mul_start_o | div_start_o; // mthi/mtlo never stall

endmodule

//--- common/lane_if.sv
`timescale 1ns/1ps

interface lane_if;
    import exec_pkg::*;

    alu_op_e             op;
    logic [XLEN-1:0]     src_a;
    logic [XLEN-1:0]     src_b;
    logic [4:0]          shamt;
    logic [2*XLEN-1:0]   hilo;    // current hi/lo, for mfhi/mflo
    logic [XLEN-1:0]     result;
    logic                overflow;

    modport disp (output op, src_a, src_b, shamt);

    modport alu (input op, src_a, src_b, shamt, hilo, output result, overflow);

    modport wb (input result, overflow, output hilo);

endinterface

//--- common/muldiv_pkg.sv
package muldiv_pkg;

    // what the shared unit does with hi/lo
    typedef enum logic [2:0] {
        MD_NONE = 3'd0,
        MD_MUL  = 3'd1,
        MD_MADD = 3'd2,
        MD_MSUB = 3'd3,
        MD_DIV  = 3'd4,
        MD_MTHI = 3'd5,
        MD_MTLO = 3'd6
    } muldiv_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_FIX  = 2'd2, // sign correction
        DIV_DONE = 2'd3
    } div_state_e;

endpackage

//--- common/exec_pkg.sv
package exec_pkg;

    parameter int XLEN = 32;

    // opcode per issue slot
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_ADD   = 8'h01, // traps on overflow in the full core, flag only here
        OP_ADDU  = 8'h02,
        OP_SUB   = 8'h03,
        OP_SUBU  = 8'h04,
        OP_AND   = 8'h05,
        OP_OR    = 8'h06,
        OP_XOR   = 8'h07,
        OP_NOR   = 8'h08,
        OP_SLT   = 8'h09,
        OP_SLTU  = 8'h0a,
        OP_SLL   = 8'h0b,
        OP_SRL   = 8'h0c,
        OP_SRA   = 8'h0d,
        OP_LUI   = 8'h0e,
        OP_MFHI  = 8'h10, // hi/lo group
        OP_MFLO  = 8'h11,
        OP_MTHI  = 8'h12,
        OP_MTLO  = 8'h13,
        OP_MULT  = 8'h20, // multiply/divide group
        OP_MULTU = 8'h21,
        OP_MADD  = 8'h22,
        OP_MSUB  = 8'h23,
        OP_DIV   = 8'h24,
        OP_DIVU  = 8'h25
    } alu_op_e;

endpackage
